/* Bender.yml */
package:
  name: rv_exec_top

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/exec_ctrl_if.sv
      - src/main_decoder.sv
      - src/alu_decoder.sv
      - src/decode_stage.sv
      - src/execute_unit.sv
      - src/rv_exec_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_rv_exec_top.sv

/* build.f */
+incdir+src
src/rv_pkg.sv
src/exec_ctrl_if.sv
src/main_decoder.sv
src/alu_decoder.sv
src/decode_stage.sv
src/execute_unit.sv
src/rv_exec_top.sv
testbench/tb_rv_exec_top.sv

/* src/alu_decoder.sv */
/*
 * ALU decoder.
 * ALU op group, funct3, funct7[5] and opcode[5] to ALU control.
 */

`default_nettype none

module alu_decoder (
    input  rv_pkg::alu_op_e     i_alu_op,
    input  logic [2:0]          i_func_3,
    input  logic                i_func_7_5,
    input  logic                i_op_5,     // Set for register-register forms.

    output rv_pkg::alu_ctrl_e   o_alu_control,
    output logic                o_illegal_instr
);

    logic [1:0] op_func_7;

    assign op_func_7 = {i_op_5, i_func_7_5};

    always_comb begin
        o_alu_control   = rv_pkg::ADD;
        o_illegal_instr = 1'b0;

        case (i_alu_op)
            rv_pkg::ADD_ADDR: o_alu_control = rv_pkg::ADD; // Load, store.
            rv_pkg::SUB_CMP:  o_alu_control = rv_pkg::SUB; // Branches.

            // Full width ------------------------
            rv_pkg::INT: begin
                case (i_func_3)
                    3'b000: begin
                        if (op_func_7 == 2'b11) o_alu_control = rv_pkg::SUB;
                        else                    o_alu_control = rv_pkg::ADD; // ADDI too.
                    end
                    3'b001: o_alu_control = rv_pkg::SLL;
                    3'b010: o_alu_control = rv_pkg::SLT;
                    3'b011: o_alu_control = rv_pkg::SLTU;
                    3'b100: o_alu_control = rv_pkg::XOR;
                    3'b101: begin
                        if (i_func_7_5) o_alu_control = rv_pkg::SRA;
                        else            o_alu_control = rv_pkg::SRL;
                    end
                    3'b110: o_alu_control = rv_pkg::OR;
                    default: o_alu_control = rv_pkg::AND;
                endcase
            end

            // 32-bit forms ------------------------
            rv_pkg::INT_W: begin
                case (i_func_3)
                    3'b000: begin
                        case (op_func_7)
                            2'b11:   o_alu_control = rv_pkg::SUBW;
                            2'b10:   o_alu_control = rv_pkg::ADDW;
                            default: o_alu_control = rv_pkg::ADDIW;
                        endcase
                    end
                    3'b001: o_alu_control = rv_pkg::SLLW; // SLLW, SLLIW.
                    3'b101: begin
                        if (i_func_7_5) o_alu_control = rv_pkg::SRAW;
                        else            o_alu_control = rv_pkg::SRLW;
                    end
                    default: o_illegal_instr = 1'b1;
                endcase
            end

            // CSR, funct3[2] only picks the operand.
            rv_pkg::CSR: begin
                case (i_func_3[1:0])
                    2'b01:   o_alu_control = rv_pkg::CSRRW;
                    2'b10:   o_alu_control = rv_pkg::CSRRS;
                    2'b11:   o_alu_control = rv_pkg::CSRRC;
                    default: o_illegal_instr = 1'b1; // ECALL, EBREAK space.
                endcase
            end

            default: o_illegal_instr = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
/*
 * Decode stage.
 * Splits the word, builds the immediate, picks operands and
 * registers the item into the execute link.
 */

`default_nettype none
`include "rv_defs.svh"

module decode_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  rv_pkg::instr_u      i_instr,
    input  logic [`RV_XLEN-1:0] i_rs1_data,
    input  logic [`RV_XLEN-1:0] i_rs2_data,
    input  logic [`RV_XLEN-1:0] i_csr_rdata,

    exec_ctrl_if.src            o_ctrl
);

    rv_pkg::alu_op_e     alu_op;
    rv_pkg::imm_kind_e   imm_kind;
    rv_pkg::alu_ctrl_e   alu_ctrl;
    logic                src_imm;
    logic                reg_write;
    logic                csr_write;
    logic                main_illegal;
    logic                alu_illegal;
    logic                illegal;
    logic [`RV_XLEN-1:0] imm;

    main_decoder u_main_dec (
        .i_opcode    (i_instr.r.opcode),
        .o_alu_op    (alu_op),
        .o_imm_kind  (imm_kind),
        .o_src_imm   (src_imm),
        .o_reg_write (reg_write),
        .o_csr_write (csr_write),
        .o_illegal   (main_illegal)
    );

    alu_decoder u_alu_dec (
        .i_alu_op        (alu_op),
        .i_func_3        (i_instr.r.funct3),
        .i_func_7_5      (i_instr.r.funct7[5]),
        .i_op_5          (i_instr.r.opcode[5]),
        .o_alu_control   (alu_ctrl),
        .o_illegal_instr (alu_illegal)
    );

    assign illegal = main_illegal | alu_illegal;

    // Immediate ------------------------
    always_comb begin
        case (imm_kind)
            rv_pkg::I: imm = {{(`RV_XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
            rv_pkg::S: imm = {{(`RV_XLEN-12){i_instr.s.imm_hi[6]}},
                              i_instr.s.imm_hi, i_instr.s.imm_lo};
            rv_pkg::B: imm = {{(`RV_XLEN-13){i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi[6],
                              i_instr.s.imm_lo[0], i_instr.s.imm_hi[5:0],
                              i_instr.s.imm_lo[4:1], 1'b0};
            default:   imm = {{(`RV_XLEN-5){1'b0}}, i_instr.i.rs1}; // CSR uimm.
        endcase
    end

    // Control, cleared on reset.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ctrl.valid     <= 1'b0;
            o_ctrl.reg_write <= 1'b0;
            o_ctrl.csr_write <= 1'b0;
            o_ctrl.illegal   <= 1'b0;
        end else begin
            o_ctrl.valid     <= i_valid;
            o_ctrl.reg_write <= i_valid & reg_write & ~illegal & (i_instr.r.rd != 5'd0);
            o_ctrl.csr_write <= i_valid & csr_write & ~illegal;
            o_ctrl.illegal   <= i_valid & illegal;
        end
    end

    // Payload.
    always_ff @(posedge i_clk) begin
        o_ctrl.alu_ctrl  <= alu_ctrl;
        o_ctrl.op_a      <= (alu_op == rv_pkg::CSR && i_instr.r.funct3[2]) ? imm : i_rs1_data;
        o_ctrl.op_b      <= src_imm ? imm : i_rs2_data;
        o_ctrl.csr_rdata <= i_csr_rdata;
        o_ctrl.rd_addr   <= i_instr.r.rd;
    end

endmodule

`default_nettype wire

/* src/exec_ctrl_if.sv */
/*
 * Decode to execute link.
 * Registered control and operands of one instruction.
 */

`default_nettype none
`include "rv_defs.svh"

interface exec_ctrl_if;
    logic                  valid;     // One item per high cycle.
    rv_pkg::alu_ctrl_e     alu_ctrl;
    logic [`RV_XLEN-1:0]   op_a;
    logic [`RV_XLEN-1:0]   op_b;
    logic [`RV_XLEN-1:0]   csr_rdata; // Old CSR value.
    logic [4:0]            rd_addr;
    logic                  reg_write;
    logic                  csr_write;
    logic                  illegal;

    modport src (output valid, alu_ctrl, op_a, op_b, csr_rdata,
                 rd_addr, reg_write, csr_write, illegal);
    modport dst (input  valid, alu_ctrl, op_a, op_b, csr_rdata,
                 rd_addr, reg_write, csr_write, illegal);
endinterface

`default_nettype wire

/* src/execute_unit.sv */
/*
 * Execute unit.
 * 64-bit ALU with the 32-bit W forms and CSR read-modify-write,
 * all results registered.
 */

`default_nettype none
`include "rv_defs.svh"

module execute_unit (
    input  logic                i_clk,
    input  logic                i_rst,
    exec_ctrl_if.dst            i_ctrl,

    output logic                o_valid,
    output logic [`RV_XLEN-1:0] o_result,
    output logic [4:0]          o_rd_addr,
    output logic                o_reg_write,
    output logic [`RV_XLEN-1:0] o_csr_wdata,
    output logic                o_csr_write,
    output logic                o_illegal
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [5:0]          shamt;     // Full width shift amount.
    logic [4:0]          shamt_w;   // W shift amount.
    logic [31:0]         add_w;     // ADDW and ADDIW.
    logic [31:0]         w_res;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] csr_wdata;

    assign op_a    = i_ctrl.op_a;
    assign op_b    = i_ctrl.op_b;
    assign shamt   = op_b[5:0];
    assign shamt_w = op_b[4:0];
    assign add_w   = op_a[31:0] + op_b[31:0];

    // 32-bit forms ------------------------
    always_comb begin
        case (i_ctrl.alu_ctrl)
            rv_pkg::SUBW: w_res = op_a[31:0] - op_b[31:0];
            rv_pkg::SLLW: w_res = op_a[31:0] << shamt_w;
            rv_pkg::SRLW: w_res = op_a[31:0] >> shamt_w;
            rv_pkg::SRAW: w_res = $signed(op_a[31:0]) >>> shamt_w;
            default:      w_res = add_w; // ADDW, ADDIW.
        endcase
    end

    // Main ALU ------------------------
    always_comb begin
        case (i_ctrl.alu_ctrl)
            rv_pkg::ADD:  alu_res = op_a + op_b;
            rv_pkg::SUB:  alu_res = op_a - op_b;
            rv_pkg::AND:  alu_res = op_a & op_b;
            rv_pkg::OR:   alu_res = op_a | op_b;
            rv_pkg::XOR:  alu_res = op_a ^ op_b;
            rv_pkg::SLL:  alu_res = op_a << shamt;
            rv_pkg::SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::SRL:  alu_res = op_a >> shamt;
            rv_pkg::SRA:  alu_res = $signed(op_a) >>> shamt;
            rv_pkg::ADDW, rv_pkg::SUBW, rv_pkg::SLLW, rv_pkg::SRLW, rv_pkg::SRAW,
            rv_pkg::ADDIW:
                alu_res = {{(`RV_XLEN-32){w_res[31]}}, w_res}; // Sign-extend.
            rv_pkg::CSRRW, rv_pkg::CSRRS, rv_pkg::CSRRC:
                alu_res = i_ctrl.csr_rdata; // rd gets the old CSR.
            default: alu_res = '0;
        endcase
    end

    // New CSR value, op_a is rs1 or uimm.
    always_comb begin
        case (i_ctrl.alu_ctrl)
            rv_pkg::CSRRS: csr_wdata = i_ctrl.csr_rdata | op_a;
            rv_pkg::CSRRC: csr_wdata = i_ctrl.csr_rdata & ~op_a;
            default:       csr_wdata = op_a; // CSRRW.
        endcase
    end

    // Output register ------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_csr_write <= 1'b0;
            o_illegal   <= 1'b0;
        end else begin
            o_valid     <= i_ctrl.valid;
            o_reg_write <= i_ctrl.reg_write;
            o_csr_write <= i_ctrl.csr_write;
            o_illegal   <= i_ctrl.illegal;
        end
    end

    always_ff @(posedge i_clk) begin
        o_result    <= i_ctrl.illegal ? '0 : alu_res; // Zero for illegal.
        o_rd_addr   <= i_ctrl.rd_addr;
        o_csr_wdata <= csr_wdata;
    end

endmodule

`default_nettype wire

/* src/main_decoder.sv */
/*
 * Main decoder.
 * Opcode to ALU op group, immediate kind, operand source and writes.
 */

`default_nettype none
`include "rv_defs.svh"

module main_decoder (
    input  logic [6:0]          i_opcode,

    output rv_pkg::alu_op_e     o_alu_op,
    output rv_pkg::imm_kind_e   o_imm_kind,
    output logic                o_src_imm,   // Operand B from immediate.
    output logic                o_reg_write,
    output logic                o_csr_write,
    output logic                o_illegal
);

    always_comb begin
        o_alu_op    = rv_pkg::ADD_ADDR;
        o_imm_kind  = rv_pkg::I;
        o_src_imm   = 1'b0;
        o_reg_write = 1'b0;
        o_csr_write = 1'b0;
        o_illegal   = 1'b0;

        case (i_opcode)
            `RV_OPC_LOAD: begin
                o_src_imm   = 1'b1; // rs1 + imm.
                o_reg_write = 1'b1;
            end
            `RV_OPC_STORE: begin
                o_imm_kind  = rv_pkg::S;
                o_src_imm   = 1'b1;
            end
            `RV_OPC_BRANCH: begin
                o_alu_op    = rv_pkg::SUB_CMP; // rs1 - rs2, no write.
                o_imm_kind  = rv_pkg::B;
            end
            `RV_OPC_OP_IMM: begin
                o_alu_op    = rv_pkg::INT;
                o_src_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            `RV_OPC_OP: begin
                o_alu_op    = rv_pkg::INT;
                o_reg_write = 1'b1;
            end
            `RV_OPC_OP_IMM_32: begin
                o_alu_op    = rv_pkg::INT_W;
                o_src_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            `RV_OPC_OP_32: begin
                o_alu_op    = rv_pkg::INT_W;
                o_reg_write = 1'b1;
            end
            `RV_OPC_SYSTEM: begin
                o_alu_op    = rv_pkg::CSR;
                o_imm_kind  = rv_pkg::ZIMM; // Used by the I variants.
                o_reg_write = 1'b1;
                o_csr_write = 1'b1;
            end
            default: o_illegal = 1'b1; // LUI, AUIPC, JAL, JALR and the rest.
        endcase
    end

endmodule

`default_nettype wire

/* src/rv_defs.svh */
/*
 * RV64I execute core definitions.
 * Data width and the major opcode values used by the decoders.
 */

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN 64 // Integer register width.

// Major opcodes ------------------------
`define RV_OPC_LOAD      7'b0000011
`define RV_OPC_STORE     7'b0100011
`define RV_OPC_BRANCH    7'b1100011
`define RV_OPC_OP_IMM    7'b0010011
`define RV_OPC_OP        7'b0110011
`define RV_OPC_OP_IMM_32 7'b0011011
`define RV_OPC_OP_32     7'b0111011
`define RV_OPC_SYSTEM    7'b1110011 // CSR forms only.

`endif

/* src/rv_exec_top.sv */
/*
 * RV64I decode and execute top.
 * Decode stage and execute unit joined by the control link;
 * results leave 2 cycles after the input strobe.
 */

`default_nettype none
`include "rv_defs.svh"

module rv_exec_top (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,     // One-cycle strobe.
    input  logic [31:0]         i_instr,
    input  logic [`RV_XLEN-1:0] i_rs1_data,
    input  logic [`RV_XLEN-1:0] i_rs2_data,
    input  logic [`RV_XLEN-1:0] i_csr_rdata,

    output logic                o_valid,
    output logic [`RV_XLEN-1:0] o_result,
    output logic [4:0]          o_rd_addr,
    output logic                o_reg_write,
    output logic [`RV_XLEN-1:0] o_csr_wdata,
    output logic                o_csr_write,
    output logic                o_illegal
);

    exec_ctrl_if u_ctrl_if ();

    decode_stage u_decode (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_instr     (i_instr),
        .i_rs1_data  (i_rs1_data),
        .i_rs2_data  (i_rs2_data),
        .i_csr_rdata (i_csr_rdata),
        .o_ctrl      (u_ctrl_if.src)
    );

    execute_unit u_execute (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_ctrl      (u_ctrl_if.dst),
        .o_valid     (o_valid),
        .o_result    (o_result),
        .o_rd_addr   (o_rd_addr),
        .o_reg_write (o_reg_write),
        .o_csr_wdata (o_csr_wdata),
        .o_csr_write (o_csr_write),
        .o_illegal   (o_illegal)
    );

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
/*
 * RV64I core package.
 * ALU op groups, ALU control codes, immediate kinds and the
 * instruction word with its R, I and S format views.
 */

`default_nettype none

package rv_pkg;

    typedef enum logic [2:0] {
        ADD_ADDR = 3'b000, // Load and store address.
        SUB_CMP  = 3'b001, // Branch compare.
        INT      = 3'b010, // OP and OP-IMM.
        INT_W    = 3'b011, // 32-bit forms.
        CSR      = 3'b100
    } alu_op_e;

    typedef enum logic [4:0] {
        ADD   = 5'b00000, SUB   = 5'b00001, AND   = 5'b00010, OR    = 5'b00011,
        XOR   = 5'b00100, SLL   = 5'b00101, SLT   = 5'b00110, SLTU  = 5'b00111,
        SRL   = 5'b01000, SRA   = 5'b01001,
        ADDW  = 5'b01010, SUBW  = 5'b01011, SLLW  = 5'b01100, SRLW  = 5'b01101,
        SRAW  = 5'b01110, ADDIW = 5'b01111,
        CSRRW = 5'b10000, CSRRS = 5'b10001, CSRRC = 5'b10010
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        I, S, B,
        ZIMM // Zero-extended rs1 field.
    } imm_kind_e;

    // Same 32 bits, read per format.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi; // Also B imm[12|10:5].
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo; // Also B imm[4:1|11].
            logic [6:0] opcode;
        } s;
    } instr_u;

endpackage

`default_nettype wire

/* testbench/tb_rv_exec_top.sv */
/*
 * Testbench for the RV64I decode and execute top.
 * Directed tests over the integer, W, address, CSR and illegal paths,
 * then back-to-back strobes with exact latency and ordering.
 */

`default_nettype none
`include "rv_defs.svh"

module tb_rv_exec_top;
    timeunit 1ns;
    timeprecision 1ps;

    logic                i_clk = 1'b0;
    logic                i_rst;
    logic                i_valid;
    logic [31:0]         i_instr;
    logic [`RV_XLEN-1:0] i_rs1_data;
    logic [`RV_XLEN-1:0] i_rs2_data;
    logic [`RV_XLEN-1:0] i_csr_rdata;
    logic                o_valid;
    logic [`RV_XLEN-1:0] o_result;
    logic [4:0]          o_rd_addr;
    logic                o_reg_write;
    logic [`RV_XLEN-1:0] o_csr_wdata;
    logic                o_csr_write;
    logic                o_illegal;

    logic [31:0] lfsr = 32'h526580b8; // Stimulus seed.

    rv_exec_top UUT (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_instr     (i_instr),
        .i_rs1_data  (i_rs1_data),
        .i_rs2_data  (i_rs2_data),
        .i_csr_rdata (i_csr_rdata),
        .o_valid     (o_valid),
        .o_result    (o_result),
        .o_rd_addr   (o_rd_addr),
        .o_reg_write (o_reg_write),
        .o_csr_wdata (o_csr_wdata),
        .o_csr_write (o_csr_write),
        .o_illegal   (o_illegal)
    );

    always #10 i_clk = ~i_clk; // 20 ns period.

    // Helpers ------------------------
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // Galois step.
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w}; // W result to 64 bits.
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], `RV_OPC_STORE}; // SD.
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `RV_OPC_BRANCH}; // BEQ.
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first failure.");
    endtask

    // Compare tasks ------------------------
    task automatic check_result(input logic [`RV_XLEN-1:0] got, exp, input string what);
        if (got !== exp)
            abort_run($sformatf("** Error at %0d ns: %s result %h, expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_ctrl(input logic [4:0] got_rd, exp_rd,
                              input logic got_rw, exp_rw, got_cw, exp_cw, got_ill, exp_ill,
                              input string what);
        if ({got_rd, got_rw, got_cw, got_ill} !== {exp_rd, exp_rw, exp_cw, exp_ill})
            abort_run($sformatf(
                "** Error at %0d ns: %s rd/rw/cw/ill %0d/%b/%b/%b, expected %0d/%b/%b/%b",
                $time, what, got_rd, got_rw, got_cw, got_ill, exp_rd, exp_rw, exp_cw, exp_ill));
    endtask

    task automatic check_csr(input logic [`RV_XLEN-1:0] got, exp, input string what);
        if (got !== exp)
            abort_run($sformatf("** Error at %0d ns: %s CSR write data %h, expected %h",
                                $time, what, got, exp));
    endtask

    // One strobe, then wait for its response.
    task automatic run_item(input logic [31:0] instr, input logic [`RV_XLEN-1:0] rs1, rs2, csr,
                            input logic [`RV_XLEN-1:0] exp_res, exp_csr,
                            input logic exp_rw, exp_cw, exp_ill, input string what);
        int waited = 0;
        @(posedge i_clk);
        i_valid     <= 1'b1;
        i_instr     <= instr;
        i_rs1_data  <= rs1;
        i_rs2_data  <= rs2;
        i_csr_rdata <= csr;
        @(posedge i_clk);
        i_valid     <= 1'b0; // Single-cycle strobe.
        do begin
            @(negedge i_clk); // Outputs settled here.
            waited++;
        end while (!o_valid && waited < 10);
        if (!o_valid)
            abort_run($sformatf("Timeout: o_valid never came for %s.", what));
        check_result(o_result, exp_res, what);
        check_ctrl(o_rd_addr, instr[11:7], o_reg_write, exp_rw, o_csr_write, exp_cw,
                   o_illegal, exp_ill, what);
        if (exp_cw)
            check_csr(o_csr_wdata, exp_csr, what);
    endtask

    // Register-writing item, no CSR side.
    task automatic run_alu(input logic [31:0] instr, input logic [`RV_XLEN-1:0] rs1, rs2, exp,
                           input string what);
        run_item(instr, rs1, rs2, '0, exp, '0, instr[11:7] != 5'd0, 1'b0, 1'b0, what);
    endtask

    // Tests ------------------------
    task automatic test_int_ops();
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [11:0]         imm;
        for (int n = 0; n < 4; n++) begin
            a   = take_bits(64);
            b   = take_bits(64);
            imm = 12'(take_bits(12)) | 12'h400; // Bit 10 set, still ADDI.
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, `RV_OPC_OP), a, b, a + b, "ADD");
            run_alu(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4, `RV_OPC_OP), a, b, a - b, "SUB");
            run_alu(enc_i(imm, 5'd1, 3'b000, 5'd5, `RV_OPC_OP_IMM), a, b, a + sext12(imm), "ADDI");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd6, `RV_OPC_OP), a, b, a & b, "AND");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd7, `RV_OPC_OP), a, b, a | b, "OR");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8, `RV_OPC_OP), a, b, a ^ b, "XOR");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd9, `RV_OPC_OP), a, b,
                    ($signed(a) < $signed(b)) ? 64'd1 : 64'd0, "SLT");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd10, `RV_OPC_OP), a, b,
                    (a < b) ? 64'd1 : 64'd0, "SLTU");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd11, `RV_OPC_OP), a, b, a << b[5:0], "SLL");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd12, `RV_OPC_OP), a, b, a >> b[5:0], "SRL");
            run_alu(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd13, `RV_OPC_OP), a, b,
                    $signed(a) >>> b[5:0], "SRA");
            run_alu(enc_i({6'b010000, b[5:0]}, 5'd1, 3'b101, 5'd14, `RV_OPC_OP_IMM), a, b,
                    $signed(a) >>> b[5:0], "SRAI");
        end
    endtask

    task automatic test_w_ops();
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [11:0]         imm;
        for (int n = 0; n < 4; n++) begin
            a   = take_bits(64);
            b   = take_bits(64);
            imm = 12'(take_bits(12));
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, `RV_OPC_OP_32), a, b,
                    sext32(a[31:0] + b[31:0]), "ADDW");
            run_alu(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4, `RV_OPC_OP_32), a, b,
                    sext32(a[31:0] - b[31:0]), "SUBW");
            run_alu(enc_i(imm, 5'd1, 3'b000, 5'd5, `RV_OPC_OP_IMM_32), a, b,
                    sext32(a[31:0] + {{20{imm[11]}}, imm}), "ADDIW");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd6, `RV_OPC_OP_32), a, b,
                    sext32(a[31:0] << b[4:0]), "SLLW");
            run_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd7, `RV_OPC_OP_32), a, b,
                    sext32(a[31:0] >> b[4:0]), "SRLW");
            run_alu(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd8, `RV_OPC_OP_32), a, b,
                    sext32($signed(a[31:0]) >>> b[4:0]), "SRAW");
        end
    endtask

    task automatic test_mem_branch();
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [11:0]         imm;
        logic [12:0]         bimm;
        a    = take_bits(64);
        b    = take_bits(64);
        imm  = 12'(take_bits(12));
        bimm = 13'(take_bits(12)) << 1; // Branch offsets are even.
        run_alu(enc_i(imm, 5'd1, 3'b011, 5'd9, `RV_OPC_LOAD), a, b, a + sext12(imm), "LD");
        run_alu(enc_i(imm, 5'd1, 3'b011, 5'd0, `RV_OPC_LOAD), a, b, a + sext12(imm), "LD x0");
        run_item(enc_s(imm, 5'd2, 5'd1), a, b, '0, a + sext12(imm), '0, 1'b0, 1'b0, 1'b0, "SD");
        run_item(enc_b(bimm, 5'd2, 5'd1), a, b, '0, a - b, '0, 1'b0, 1'b0, 1'b0, "BEQ");
    endtask

    task automatic test_csr_ops();
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] csr;
        logic [4:0]          uimm;
        logic [`RV_XLEN-1:0] zimm;
        a    = take_bits(64);
        csr  = take_bits(64);
        uimm = 5'(take_bits(5)) | 5'd1; // Nonzero immediate.
        zimm = {59'd0, uimm};
        run_item(enc_i(12'h340, 5'd1, 3'b001, 5'd5, `RV_OPC_SYSTEM), a, '0, csr, csr, a,
                 1'b1, 1'b1, 1'b0, "CSRRW");
        run_item(enc_i(12'h340, 5'd1, 3'b001, 5'd0, `RV_OPC_SYSTEM), a, '0, csr, csr, a,
                 1'b0, 1'b1, 1'b0, "CSRRW x0");
        run_item(enc_i(12'h340, 5'd1, 3'b010, 5'd6, `RV_OPC_SYSTEM), a, '0, csr, csr, csr | a,
                 1'b1, 1'b1, 1'b0, "CSRRS");
        run_item(enc_i(12'h340, 5'd1, 3'b011, 5'd7, `RV_OPC_SYSTEM), a, '0, csr, csr, csr & ~a,
                 1'b1, 1'b1, 1'b0, "CSRRC");
        run_item(enc_i(12'h341, uimm, 3'b101, 5'd8, `RV_OPC_SYSTEM), a, '0, csr, csr, zimm,
                 1'b1, 1'b1, 1'b0, "CSRRWI");
        run_item(enc_i(12'h341, uimm, 3'b110, 5'd9, `RV_OPC_SYSTEM), a, '0, csr, csr,
                 csr | zimm, 1'b1, 1'b1, 1'b0, "CSRRSI");
        run_item(enc_i(12'h341, uimm, 3'b111, 5'd10, `RV_OPC_SYSTEM), a, '0, csr, csr,
                 csr & ~zimm, 1'b1, 1'b1, 1'b0, "CSRRCI");
    endtask

    task automatic test_illegal();
        logic [`RV_XLEN-1:0] a;
        a = take_bits(64);
        run_item({20'(take_bits(20)), 5'd7, 7'b0110111}, a, a, a, '0, '0,
                 1'b0, 1'b0, 1'b1, "LUI");
        run_item(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8, `RV_OPC_OP_32), a, a, a, '0, '0,
                 1'b0, 1'b0, 1'b1, "W funct3 010");
        run_item(enc_i(12'h000, 5'd0, 3'b000, 5'd9, `RV_OPC_SYSTEM), a, a, a, '0, '0,
                 1'b0, 1'b0, 1'b1, "CSR funct3 000");
        run_item(enc_i(12'h340, 5'd1, 3'b100, 5'd9, `RV_OPC_SYSTEM), a, a, a, '0, '0,
                 1'b0, 1'b0, 1'b1, "CSR funct3 100");
    endtask

    // Strobes on consecutive cycles, responses exactly 2 cycles later.
    task automatic test_back_to_back();
        logic [31:0]         instr   [5];
        logic [`RV_XLEN-1:0] op_a    [5];
        logic [`RV_XLEN-1:0] op_b    [5];
        logic [`RV_XLEN-1:0] exp_res [5];
        logic                busy;
        for (int n = 0; n < 5; n++) begin
            op_a[n] = take_bits(64);
            op_b[n] = take_bits(64);
        end
        instr[0]   = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd11, `RV_OPC_OP);
        exp_res[0] = op_a[0] + op_b[0];
        instr[1]   = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd12, `RV_OPC_OP);
        exp_res[1] = op_a[1] - op_b[1];
        instr[2]   = enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd13, `RV_OPC_OP);
        exp_res[2] = op_a[2] ^ op_b[2];
        instr[3]   = enc_i(12'h801, 5'd1, 3'b000, 5'd14, `RV_OPC_OP_IMM_32);
        exp_res[3] = sext32(op_a[3][31:0] + 32'hfffff801);
        instr[4]   = enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd15, `RV_OPC_OP);
        exp_res[4] = $signed(op_a[4]) >>> op_b[4][5:0];
        for (int k = 0; k < 8; k++) begin
            @(posedge i_clk);
            if (k < 5) begin
                i_valid    <= 1'b1;
                i_instr    <= instr[k];
                i_rs1_data <= op_a[k];
                i_rs2_data <= op_b[k];
            end else begin
                i_valid    <= 1'b0;
            end
            @(negedge i_clk);
            busy = (k >= 2) && (k < 7); // Item k-2 due now.
            if (o_valid !== busy)
                abort_run($sformatf("** Error at %0d ns: o_valid %b in cycle %0d, expected %b",
                                    $time, o_valid, k, busy));
            if (busy) begin
                check_result(o_result, exp_res[k-2], "back-to-back");
                check_ctrl(o_rd_addr, instr[k-2][11:7], o_reg_write, 1'b1, o_csr_write, 1'b0,
                           o_illegal, 1'b0, "back-to-back");
            end
        end
    endtask

    initial begin
        i_rst       <= 1'b1;
        i_valid     <= 1'b1; // Strobe during reset is dropped.
        i_instr     <= enc_i(12'h340, 5'd1, 3'b001, 5'd5, `RV_OPC_SYSTEM); // CSRRW.
        i_rs1_data  <= '0;
        i_rs2_data  <= '0;
        i_csr_rdata <= '0;
        repeat (3) @(posedge i_clk);
        i_rst   <= 1'b0;
        i_valid <= 1'b0;
        repeat (2) begin
            @(negedge i_clk);
            if ({o_valid, o_reg_write, o_csr_write, o_illegal} !== 4'b0000)
                abort_run($sformatf("** Error at %0d ns: outputs not idle after reset", $time));
        end
        test_int_ops();
        test_w_ops();
        test_mem_branch();
        test_csr_ops();
        test_illegal();
        test_back_to_back();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
